// ==== include/rsa_defines.svh ====
`ifndef RSA_DEFINES_SVH
`define RSA_DEFINES_SVH

// operand width in bits
`define RSA_W 64

// doubling steps needed to reach R squared from 1
`define RSA_R2_STEPS (2 * `RSA_W)

// counter width, must hold RSA_R2_STEPS
`define RSA_CNT_W 8

`endif

// ==== src/rsa_pkg.sv ====
`include "rsa_defines.svh"

package rsa_pkg;

    // one operand or result word
    typedef logic [`RSA_W-1:0] rsa_word_t;

    // request as presented at the top level
    // in mode 1 exp carries the second factor
    typedef struct packed {
        logic      mode;
        rsa_word_t msg;
        rsa_word_t exp;
        rsa_word_t modulus;
    } rsa_req_t;

    // operand pair for one Montgomery product
    typedef struct packed {
        rsa_word_t x;
        rsa_word_t y;
    } mont_op_t;

endpackage

// ==== src/r2_mod_n.sv ====
`timescale 1ns/1ps
`include "rsa_defines.svh"

module r2_mod_n (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               r2_start,
    input  rsa_pkg::rsa_word_t modulus,
    output rsa_pkg::rsa_word_t r2,
    output logic               r2_done
);

    logic [`RSA_W:0]       acc;
    logic [`RSA_CNT_W-1:0] cnt;
    logic [`RSA_W+1:0]     dbl;
    logic [`RSA_W+1:0]     diff;

    // acc stays below N, so the doubled value fits and one subtract is enough
    assign dbl  = {acc, 1'b0};
    assign diff = dbl - {2'b00, modulus};

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            cnt     <= '0;
            r2_done <= 1'b0;
        end else begin
            r2_done <= 1'b0;
            if (r2_start) begin
                cnt <= `RSA_CNT_W'(`RSA_R2_STEPS);
            end else if (cnt != '0) begin
                cnt     <= cnt - 1'b1;
                r2_done <= (cnt == `RSA_CNT_W'(1));
            end
        end
    end

    always_ff @(posedge clk) begin
        if (r2_start) begin
            acc <= (`RSA_W+1)'(1);
        end else if (cnt != '0) begin
            acc <= diff[`RSA_W+1] ? dbl[`RSA_W:0] : diff[`RSA_W:0];
        end
    end

    assign r2 = acc[`RSA_W-1:0];

endmodule

// ==== src/mont_mul.sv ====
`timescale 1ns/1ps
`include "rsa_defines.svh"

module mont_mul (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               mul_start,
    input  rsa_pkg::mont_op_t  mul_op,
    input  rsa_pkg::rsa_word_t modulus,
    output rsa_pkg::rsa_word_t prod,
    output logic               mul_done
);

    // one step per bit of x, plus the final subtract
    localparam logic [`RSA_CNT_W-1:0] total_cycles = `RSA_CNT_W'(`RSA_W + 1);

    rsa_pkg::rsa_word_t    x_q;
    rsa_pkg::rsa_word_t    y_q;
    logic [`RSA_W:0]       acc;
    logic [`RSA_CNT_W-1:0] cnt;
    logic [`RSA_W+1:0]     sum_y;
    logic [`RSA_W+1:0]     sum_n;
    logic [`RSA_W+1:0]     diff;

    // acc < 2N holds across steps, so W+2 bits cover acc + y + N
    always_comb begin
        sum_y = {1'b0, acc} + (x_q[0] ? {2'b00, y_q} : '0);
        sum_n = sum_y + (sum_y[0] ? {2'b00, modulus} : '0);
    end

    assign diff = {1'b0, acc} - {2'b00, modulus};

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            cnt      <= '0;
            mul_done <= 1'b0;
        end else begin
            mul_done <= 1'b0;
            if (mul_start) begin
                cnt <= total_cycles;
            end else if (cnt != '0) begin
                cnt      <= cnt - 1'b1;
                mul_done <= (cnt == `RSA_CNT_W'(1));
            end
        end
    end

    always_ff @(posedge clk) begin
        if (mul_start) begin
            x_q <= mul_op.x;
            y_q <= mul_op.y;
            acc <= '0;
        end else if (cnt > `RSA_CNT_W'(1)) begin
            // sum_n is even here, halve it
            acc <= sum_n[`RSA_W+1:1];
            x_q <= x_q >> 1;
        end else if (cnt == `RSA_CNT_W'(1) && !diff[`RSA_W+1]) begin
            acc <= diff[`RSA_W:0];
        end
    end

    // valid while mul_done is high and until the next start
    assign prod = acc[`RSA_W-1:0];

endmodule

// ==== src/exp_ctrl.sv ====
`timescale 1ns/1ps
`include "rsa_defines.svh"

module exp_ctrl (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               start,
    input  rsa_pkg::rsa_req_t  req,
    output rsa_pkg::rsa_word_t modulus,
    output logic               r2_start,
    input  rsa_pkg::rsa_word_t r2,
    input  logic               r2_done,
    output logic               mul_start,
    output rsa_pkg::mont_op_t  mul_op,
    input  rsa_pkg::rsa_word_t prod,
    input  logic               mul_done,
    output rsa_pkg::rsa_word_t result,
    output logic               busy,
    output logic               done
);

    typedef enum logic [2:0] {
        s_idle,
        s_r2_wait,
        s_conv_in,
        s_bit_test,
        s_mul_wait,
        s_sqr_wait,
        s_conv_out,
        s_finish
    } state_t;

    localparam rsa_pkg::rsa_word_t word_one = rsa_pkg::rsa_word_t'(1);

    state_t                state;
    logic                  conv_sel;
    logic [`RSA_CNT_W-1:0] bit_cnt;
    logic                  last_bit;
    logic                  mode_q;
    rsa_pkg::rsa_word_t    msg_q;
    rsa_pkg::rsa_word_t    exp_q;
    rsa_pkg::rsa_word_t    mod_q;
    rsa_pkg::rsa_word_t    r2_q;
    rsa_pkg::rsa_word_t    c_q;
    rsa_pkg::rsa_word_t    p_q;

    assign last_bit = (bit_cnt == `RSA_CNT_W'(`RSA_W));

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state     <= s_idle;
            r2_start  <= 1'b0;
            mul_start <= 1'b0;
            conv_sel  <= 1'b0;
            bit_cnt   <= '0;
            result    <= '0;
        end else begin
            r2_start  <= 1'b0;
            mul_start <= 1'b0;
            case (state)
                s_idle: begin
                    if (start) begin
                        state    <= s_r2_wait;
                        r2_start <= 1'b1;
                        conv_sel <= 1'b0;
                        bit_cnt  <= '0;
                    end
                end
                s_r2_wait: begin
                    if (r2_done) begin
                        state     <= s_conv_in;
                        mul_start <= 1'b1;
                    end
                end
                s_conv_in: begin
                    // mode 1 converts only M while mode 0 also converts C
                    if (mul_done) begin
                        if (mode_q) begin
                            state     <= s_conv_out;
                            mul_start <= 1'b1;
                        end else if (!conv_sel) begin
                            conv_sel  <= 1'b1;
                            mul_start <= 1'b1;
                        end else begin
                            state <= s_bit_test;
                        end
                    end
                end
                s_bit_test: begin
                    mul_start <= 1'b1;
                    if (last_bit) begin
                        state <= s_conv_out;
                    end else if (exp_q[0]) begin
                        state <= s_mul_wait;
                    end else begin
                        state <= s_sqr_wait;
                    end
                end
                s_mul_wait: begin
                    if (mul_done) begin
                        state     <= s_sqr_wait;
                        mul_start <= 1'b1;
                    end
                end
                s_sqr_wait: begin
                    if (mul_done) begin
                        state   <= s_bit_test;
                        bit_cnt <= bit_cnt + 1'b1;
                    end
                end
                s_conv_out: begin
                    if (mul_done) begin
                        state  <= s_finish;
                        result <= prod;
                    end
                end
                default: state <= s_idle;
            endcase
        end
    end

    // operands and intermediate values
    always_ff @(posedge clk) begin
        case (state)
            s_idle: begin
                if (start) begin
                    mode_q <= req.mode;
                    msg_q  <= req.msg;
                    exp_q  <= req.exp;
                    mod_q  <= req.modulus;
                end
            end
            s_r2_wait: begin
                if (r2_done) begin
                    r2_q   <= r2;
                    mul_op <= '{x: msg_q, y: r2};
                end
            end
            s_conv_in: begin
                if (mul_done && !conv_sel) begin
                    p_q <= prod;
                    if (mode_q) begin
                        mul_op <= '{x: prod, y: exp_q};
                    end else begin
                        mul_op <= '{x: word_one, y: r2_q};
                    end
                end else if (mul_done) begin
                    c_q <= prod;
                end
            end
            s_bit_test: begin
                if (last_bit) begin
                    mul_op <= '{x: c_q, y: word_one};
                end else if (exp_q[0]) begin
                    mul_op <= '{x: c_q, y: p_q};
                end else begin
                    mul_op <= '{x: p_q, y: p_q};
                end
            end
            s_mul_wait: begin
                if (mul_done) begin
                    c_q    <= prod;
                    mul_op <= '{x: p_q, y: p_q};
                end
            end
            s_sqr_wait: begin
                if (mul_done) begin
                    p_q   <= prod;
                    exp_q <= exp_q >> 1;
                end
            end
            default: ;
        endcase
    end

    assign modulus = mod_q;
    // busy covers the done cycle and drops on the following edge
    assign busy    = (state != s_idle);
    assign done    = (state == s_finish);

endmodule

// ==== src/rsa_top.sv ====
`timescale 1ns/1ps

module rsa_top (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               start,
    input  rsa_pkg::rsa_req_t  req,
    output rsa_pkg::rsa_word_t result,
    output logic               busy,
    output logic               done
);

    rsa_pkg::rsa_word_t modulus;
    rsa_pkg::rsa_word_t r2;
    rsa_pkg::rsa_word_t prod;
    rsa_pkg::mont_op_t  mul_op;
    logic               r2_start;
    logic               r2_done;
    logic               mul_start;
    logic               mul_done;

    exp_ctrl u_ctrl (
        .clk       (clk),
        .rst_n     (rst_n),
        .start     (start),
        .req       (req),
        .modulus   (modulus),
        .r2_start  (r2_start),
        .r2        (r2),
        .r2_done   (r2_done),
        .mul_start (mul_start),
        .mul_op    (mul_op),
        .prod      (prod),
        .mul_done  (mul_done),
        .result    (result),
        .busy      (busy),
        .done      (done)
    );

    // both units see the modulus captured with the request
    r2_mod_n u_r2 (
        .clk      (clk),
        .rst_n    (rst_n),
        .r2_start (r2_start),
        .modulus  (modulus),
        .r2       (r2),
        .r2_done  (r2_done)
    );

    mont_mul u_mul (
        .clk       (clk),
        .rst_n     (rst_n),
        .mul_start (mul_start),
        .mul_op    (mul_op),
        .modulus   (modulus),
        .prod      (prod),
        .mul_done  (mul_done)
    );

endmodule

// ==== verif/rsa_chk.sv ====
`timescale 1ns/1ps

module rsa_chk (
    input logic clk,
    input logic rst_n,
    input logic busy,
    input logic done
);

    // busy drops on the edge that ends the done cycle
    a_busy_after_done: assert property (@(posedge clk) disable iff (!rst_n)
        done |=> !busy)
        else $error("busy still high after done");

    a_busy_fall_done: assert property (@(posedge clk) disable iff (!rst_n)
        $fell(busy) |-> $past(done))
        else $error("busy fell without a done pulse");

    a_done_single: assert property (@(posedge clk) disable iff (!rst_n)
        done |=> !done)
        else $error("done high for two cycles");

    a_done_busy: assert property (@(posedge clk) disable iff (!rst_n)
        done |-> busy)
        else $error("done while busy is low");

endmodule

// ==== verif/tb_rsa.sv ====
`timescale 1ns/1ps
`include "rsa_defines.svh"

module tb_rsa;

    // worst case request runs R squared, two conversions in, two products per bit and one out
    localparam int max_mults = 2 * `RSA_W + 3;
    localparam int op_cycles = `RSA_R2_STEPS + max_mults * (`RSA_W + 3) + 50;
    localparam int num_ops   = 44;
    localparam longint timeout_ns = longint'(num_ops) * op_cycles * 20;

    logic               clk;
    logic               rst_n;
    logic               start;
    rsa_pkg::rsa_req_t  req;
    rsa_pkg::rsa_word_t result;
    logic               busy;
    logic               done;

    int   errors;
    int   checks;
    int   done_count;
    logic done_prev;

    rsa_top DUT (
        .clk    (clk),
        .rst_n  (rst_n),
        .start  (start),
        .req    (req),
        .result (result),
        .busy   (busy),
        .done   (done)
    );

    bind rsa_top rsa_chk u_chk (
        .clk   (clk),
        .rst_n (rst_n),
        .busy  (busy),
        .done  (done)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    initial begin
        #(timeout_ns);
        $display("watchdog expired at %0t, the DUT stopped finishing requests", $time);
        $display("TESTBENCH FAILED");
        $finish;
    end

    // outputs are settled on the falling edge
    always @(negedge clk) begin
        if (rst_n) begin
            if (done) begin
                done_count++;
            end
            assert (!(done_prev && (done || busy))) else begin
                $display("%0t: done held or busy not dropped after done", $time);
                errors++;
            end
            assert (!done || busy) else begin
                $display("%0t: done pulsed while busy was low", $time);
                errors++;
            end
            done_prev = done;
        end else begin
            done_prev = 1'b0;
        end
    end

    function automatic rsa_pkg::rsa_word_t mulmod_model(rsa_pkg::rsa_word_t a,
                                                        rsa_pkg::rsa_word_t b,
                                                        rsa_pkg::rsa_word_t n);
        logic [2*`RSA_W-1:0] wide;
        wide = {`RSA_W'(0), a} * {`RSA_W'(0), b};
        wide = wide % {`RSA_W'(0), n};
        return wide[`RSA_W-1:0];
    endfunction

    // square and multiply from the lsb
    function automatic rsa_pkg::rsa_word_t powmod_model(rsa_pkg::rsa_word_t b,
                                                        rsa_pkg::rsa_word_t e,
                                                        rsa_pkg::rsa_word_t n);
        rsa_pkg::rsa_word_t acc;
        rsa_pkg::rsa_word_t base;
        int                 i;
        acc  = `RSA_W'(1);
        base = b % n;
        for (i = 0; i < `RSA_W; i++) begin
            if (e[i]) begin
                acc = mulmod_model(acc, base, n);
            end
            base = mulmod_model(base, base, n);
        end
        return acc;
    endfunction

    function automatic rsa_pkg::rsa_word_t rand_word();
        return {$urandom, $urandom};
    endfunction

    // odd with the top bit set
    function automatic rsa_pkg::rsa_word_t rand_modulus();
        return rand_word() | {1'b1, {(`RSA_W-2){1'b0}}, 1'b1};
    endfunction

    task automatic check_word(string what, rsa_pkg::rsa_word_t got, rsa_pkg::rsa_word_t want);
        checks++;
        assert (got === want) else begin
            $display("ERR %0t: %s expected %h got %h", $time, what, want, got);
            errors++;
        end
    endtask

    task automatic start_request(logic mode, rsa_pkg::rsa_word_t m, rsa_pkg::rsa_word_t e,
                                 rsa_pkg::rsa_word_t n);
        @(posedge clk);
        #2;
        start       = 1'b1;
        req.mode    = mode;
        req.msg     = m;
        req.exp     = e;
        req.modulus = n;
        @(posedge clk);
        #2;
        start = 1'b0;
    endtask

    task automatic wait_for_done();
        @(negedge clk);
        check_word("busy after start", `RSA_W'(busy), `RSA_W'(1));
        while (!done) begin
            @(negedge clk);
        end
    endtask

    task automatic run_and_check(logic mode, rsa_pkg::rsa_word_t m, rsa_pkg::rsa_word_t e,
                                 rsa_pkg::rsa_word_t n, string what);
        rsa_pkg::rsa_word_t want;
        want = mode ? mulmod_model(m, e, n) : powmod_model(m, e, n);
        start_request(mode, m, e, n);
        wait_for_done();
        check_word(what, result, want);
    endtask

    task automatic report_test(string name, int mark);
        $display("test %s: %0d errors", name, errors - mark);
    endtask

    initial begin
        int                 mark;
        int                 count0;
        rsa_pkg::rsa_word_t n;
        rsa_pkg::rsa_word_t m;
        rsa_pkg::rsa_word_t e;
        rsa_pkg::rsa_word_t want;
        void'($urandom(87));
        errors     = 0;
        checks     = 0;
        done_count = 0;
        done_prev  = 1'b0;
        rst_n      = 1'b0;
        start      = 1'b0;
        req        = '0;
        repeat (2) @(posedge clk);
        #2;
        rst_n = 1'b1;

        mark = errors;
        @(negedge clk);
        check_word("reset busy", `RSA_W'(busy), '0);
        check_word("reset done", `RSA_W'(done), '0);
        check_word("reset result", result, '0);
        report_test("reset", mark);

        mark = errors;
        repeat (20) begin
            n = rand_modulus();
            m = rand_word() % n;
            e = rand_word();
            run_and_check(1'b0, m, e, n, "random powmod");
        end
        report_test("random exponentiation", mark);

        mark = errors;
        repeat (20) begin
            n = rand_modulus();
            m = rand_word() % n;
            e = rand_word() % n;
            run_and_check(1'b1, m, e, n, "random mulmod");
        end
        report_test("random multiplication", mark);

        mark = errors;
        n = rand_modulus();
        m = rand_word() % n;
        run_and_check(1'b0, m, `RSA_W'(0), n, "exponent 0");
        run_and_check(1'b0, m, `RSA_W'(1), n, "exponent 1");
        run_and_check(1'b0, m, `RSA_W'(2), n, "exponent 2");
        report_test("edge exponents", mark);

        // second pulse lands mid-run and must not be captured
        mark   = errors;
        n      = rand_modulus();
        m      = rand_word() % n;
        e      = rand_word();
        want   = powmod_model(m, e, n);
        start_request(1'b0, m, e, n);
        count0 = done_count;
        repeat (5) @(posedge clk);
        start_request(1'b1, rand_word() % n, `RSA_W'(3), n);
        wait_for_done();
        check_word("ignored start result", result, want);
        check_word("busy with done", `RSA_W'(busy), `RSA_W'(1));
        @(negedge clk);
        check_word("busy after done", `RSA_W'(busy), '0);
        repeat (`RSA_R2_STEPS + 3 * (`RSA_W + 3) + 10) @(posedge clk);
        check_word("done pulses", `RSA_W'(done_count - count0), `RSA_W'(1));
        report_test("ignored start", mark);

        $display("summary: 5 tests, %0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

// ==== verilog.f ====
+incdir+include
src/rsa_pkg.sv
src/r2_mod_n.sv
src/mont_mul.sv
src/exp_ctrl.sv
src/rsa_top.sv
verif/rsa_chk.sv
verif/tb_rsa.sv

// ==== Makefile ====
VERILATOR  ?= verilator
FILELIST   ?= verilog.f
TB_TOP     ?= tb_rsa
RTL_TOP    ?= rsa_top
OBJ_DIR    ?= obj_dir
LOG        ?= sim.log
LINT_FLAGS ?= --lint-only -Wall
SIM_FLAGS  ?= --binary --timing --assert -Wno-fatal -j 0

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST) --top-module $(TB_TOP)

build:
	$(VERILATOR) $(SIM_FLAGS) -f $(FILELIST) --top-module $(TB_TOP) -Mdir $(OBJ_DIR)

sim: build
	./$(OBJ_DIR)/V$(TB_TOP) | tee $(LOG)
	@if grep -q "TESTBENCH FAILED" $(LOG); then echo "simulation failed"; exit 1; fi
	@grep -q "TESTBENCH PASSED" $(LOG) || (echo "no pass line in $(LOG)"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
